//--- ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::ex_op_e          op,
    input  logic                    use_imm,     // I-type form
    input  logic [ex_pkg::XLEN-1:0] pc,
    input  logic [ex_pkg::XLEN-1:0] imm,
    input  logic [ex_pkg::XLEN-1:0] fwd_a,       // rs1 after bypass
    input  logic [ex_pkg::XLEN-1:0] fwd_b,       // rs2 after bypass
    input  logic [ex_pkg::XLEN-1:0] product,     // from the multiplier
    output logic [ex_pkg::XLEN-1:0] alu_result
);
    import ex_pkg::*;

    logic [XLEN-1:0]         opnd_b;
    logic [$clog2(XLEN)-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic [XLEN-1:0]         link_addr;
    logic [XLEN-1:0]         br_target;

    // operand b mux
    assign opnd_b = use_imm ? imm : fwd_b;
    assign shamt  = opnd_b[$clog2(XLEN)-1:0];   // rv64 shift uses six bits

    // compares for slt/sltu
    assign lt_signed   = $signed(fwd_a) < $signed(opnd_b);
    assign lt_unsigned = fwd_a < opnd_b;

    assign link_addr = pc + XLEN'(4);   // jalr writes the return address
    assign br_target = pc + imm;        // branch target, checked by ex_branch

    always_comb begin
        case (op)
            ADD: begin
                alu_result = fwd_a + opnd_b;
            end
            SUB: begin
                alu_result = fwd_a - opnd_b;   // register form only in practice
            end
            SLL: begin
                alu_result = fwd_a << shamt;
            end
            SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            XOR: begin
                alu_result = fwd_a ^ opnd_b;
            end
            SRL: begin
                alu_result = fwd_a >> shamt;     // zero fill
            end
            SRA: begin
                alu_result = $unsigned($signed(fwd_a) >>> shamt);   // sign fill
            end
            OR: begin
                alu_result = fwd_a | opnd_b;
            end
            AND: begin
                alu_result = fwd_a & opnd_b;
            end
            MUL: begin
                alu_result = product;   // only meaningful once the multiplier is done
            end
            JALR: begin
                alu_result = link_addr;
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                alu_result = br_target;
            end
            default: begin
                alu_result = '0;   // NOP
            end
        endcase
    end

endmodule

//--- ex_branch.sv
`timescale 1ns/1ps

module ex_branch (
    input  ex_pkg::ex_op_e          op,
    input  logic                    held_valid,
    input  logic                    ready_ex_mem,   // redirect only when the item leaves
    input  logic [ex_pkg::XLEN-1:0] pc,
    input  logic [ex_pkg::XLEN-1:0] imm,
    input  logic                    inst_sign,      // imm sign, 1 means predicted taken
    input  logic [ex_pkg::XLEN-1:0] fwd_a,
    input  logic [ex_pkg::XLEN-1:0] fwd_b,
    input  logic [ex_pkg::XLEN-1:0] target,         // pc+imm from the alu
    output logic [ex_pkg::XLEN-1:0] dnpc,
    output logic                    pc_update
);
    import ex_pkg::*;

    logic            is_branch;
    logic            taken;        // actual direction
    logic            mispredict;
    logic [XLEN-1:0] jalr_sum;

    // condition on the bypassed operands, never on imm
    always_comb begin
        is_branch = 1'b1;
        case (op)
            BEQ:  taken = (fwd_a == fwd_b);
            BNE:  taken = (fwd_a != fwd_b);
            BLT:  taken = ($signed(fwd_a) < $signed(fwd_b));
            BGE:  taken = ($signed(fwd_a) >= $signed(fwd_b));
            BLTU: taken = (fwd_a < fwd_b);
            BGEU: taken = (fwd_a >= fwd_b);
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    // fetch guessed backward taken, forward not taken
    assign mispredict = is_branch && (taken != inst_sign);
    assign pc_update  = held_valid && ready_ex_mem && (mispredict || (op == JALR));

    assign jalr_sum = fwd_a + imm;

    always_comb begin
        if (op == JALR) begin
            dnpc = {jalr_sum[XLEN-1:1], 1'b0};   // lsb cleared per spec
        end else if (is_branch && taken) begin
            dnpc = target;
        end else begin
            dnpc = pc + XLEN'(4);                // fall through
        end
    end

endmodule

//--- ex_forward.sv
`timescale 1ns/1ps

module ex_forward (
    input  logic [ex_pkg::INST_W-1:0] inst,     // held instruction
    input  logic [ex_pkg::XLEN-1:0]   src_a,    // rs1 as read at decode
    input  logic [ex_pkg::XLEN-1:0]   src_b,    // rs2 as read at decode
    input  ex_pkg::fwd_src_t          mem_fwd,  // younger producer, wins
    input  ex_pkg::fwd_src_t          wb_fwd,   // older producer
    output logic [ex_pkg::XLEN-1:0]   fwd_a,
    output logic [ex_pkg::XLEN-1:0]   fwd_b
);
    import ex_pkg::*;

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;

    // same bypass mux for both operands
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       dec_val,
        input fwd_src_t              mem_rec,
        input fwd_src_t              wb_rec
    );
        logic [XLEN-1:0] val;
        val = dec_val;                                    // regfile value by default
        if (rs != '0) begin                               // x0 is hardwired, never bypassed
            if (mem_rec.writes && (mem_rec.rd == rs)) begin
                val = mem_rec.data;                       // newest value
            end else if (wb_rec.writes && (wb_rec.rd == rs)) begin
                val = wb_rec.data;
            end
        end
        return val;
    endfunction

    assign rs1 = inst[19:15];   // standard rv field positions
    assign rs2 = inst[24:20];

    assign fwd_a = pick_operand(rs1, src_a, mem_fwd, wb_fwd);
    assign fwd_b = pick_operand(rs2, src_b, mem_fwd, wb_fwd);

endmodule

//--- ex_multiplier.sv
`timescale 1ns/1ps

module ex_multiplier (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,         // only looked at in IDLE
    input  logic                    abort,         // flush, back to IDLE
    input  logic [ex_pkg::XLEN-1:0] multiplicand,
    input  logic [ex_pkg::XLEN-1:0] multiplier,
    input  logic                    accept,        // consumer took the product
    output logic                    done,
    output logic [ex_pkg::XLEN-1:0] product
);
    import ex_pkg::*;

    mul_state_e           state;
    logic [MUL_CNT_W-1:0] step;     // iteration index in BUSY
    logic [XLEN-1:0]      mcand;    // shifts left each step
    logic [XLEN-1:0]      mplier;   // shifts right, lsb selects the add
    logic [XLEN-1:0]      acc;      // low XLEN bits of the running sum

    // control fsm
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            step  <= '0;
        end else if (abort) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= BUSY;
                        step  <= '0;
                    end
                end
                BUSY: begin
                    step <= step + 1'b1;
                    if (step == MUL_CNT_W'(MUL_STEPS - 1)) begin
                        state <= DONE;   // MUL_STEPS cycles spent in BUSY
                    end
                end
                DONE: begin
                    if (accept) state <= IDLE;   // otherwise hold the product
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // shift-add datapath
    always_ff @(posedge clk) begin
        if ((state == IDLE) && start) begin
            mcand  <= multiplicand;   // operands latched once
            mplier <= multiplier;
            acc    <= '0;
        end else if (state == BUSY) begin
            if (mplier[0]) acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign done    = (state == DONE);
    assign product = acc;

endmodule

//--- ex_pkg.sv
package ex_pkg;

    // widths
    localparam int XLEN       = 64;   // data and address width
    localparam int REG_ADDR_W = 5;    // x0..x31
    localparam int INST_W     = 32;

    // iterative multiplier
    localparam int MUL_STEPS  = XLEN;                // one partial product per multiplier bit
    localparam int MUL_CNT_W  = $clog2(MUL_STEPS);   // step counter width

    // stage operations, NOP first so a zeroed record is a bubble
    typedef enum logic [4:0] {
        NOP,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        MUL,     // multi-cycle, stalls the stage
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JALR     // always redirects
    } ex_op_e;

    // multiplier fsm
    typedef enum logic [1:0] {
        IDLE,    // waiting for start
        BUSY,    // shift-add running
        DONE     // product held until accepted
    } mul_state_e;

    // record from decode into EX
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;     // raw instruction, rs1/rs2 fields used for forwarding
        ex_op_e            op;
        logic              use_imm;  // operand b is imm
        logic [XLEN-1:0]   src_a;    // rs1 value read at decode
        logic [XLEN-1:0]   src_b;    // rs2 value read at decode
        logic [XLEN-1:0]   imm;      // already sign-extended
    } id_ex_t;

    // forwarding record presented by MEM or WB
    typedef struct packed {
        logic                  writes;  // valid and writes a register
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } fwd_src_t;

    // record from EX toward MEM
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
        logic [XLEN-1:0]   result;   // alu value, product, link addr or branch target
    } ex_mem_t;

endpackage

//--- ex_stage_reg.sv
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic           clk,
    input  logic           rst_n,
    input  ex_pkg::id_ex_t id_ex,         // record from decode
    input  logic           valid_id_ex,
    input  logic           advance,       // load enable, low means hold
    input  logic           branch_flush,  // kills the held item at the next edge
    output ex_pkg::id_ex_t held,
    output logic           held_valid
);

    // ID/EX register
    // flush beats advance, so a redirect never lets a wrong-path item in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            held       <= '0;             // zero record decodes as NOP
        end else if (branch_flush) begin
            held_valid <= 1'b0;
            held       <= '0;
        end else if (advance) begin
            held_valid <= valid_id_ex;    // bubble loads as invalid
            held       <= id_ex;
        end
        // otherwise stall, keep everything
    end

endmodule

//--- ex_unit.sv
`timescale 1ns/1ps

module ex_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ex_pkg::id_ex_t          id_ex,
    input  logic                    valid_id_ex,
    output logic                    ready_id_ex,
    output ex_pkg::ex_mem_t         ex_mem,
    output logic                    valid_ex_mem,
    input  logic                    ready_ex_mem,
    input  ex_pkg::fwd_src_t        mem_fwd,
    input  ex_pkg::fwd_src_t        wb_fwd,
    input  logic                    branch_flush,  // level, clears EX at next edge
    output logic [ex_pkg::XLEN-1:0] dnpc,          // redirect target toward fetch
    output logic                    pc_update      // redirect strobe
);
    import ex_pkg::*;

    id_ex_t          held;
    logic            held_valid;
    logic            advance;
    logic [XLEN-1:0] fwd_a;
    logic [XLEN-1:0] fwd_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] product;
    logic            mul_done;
    logic            mul_held;    // valid MUL sitting in EX
    logic            mul_start;
    logic            block;       // multiplier still owes a result
    logic            accept;

    // stage control
    assign mul_held  = held_valid && (held.op == MUL);
    assign block     = mul_held && !mul_done;
    assign ready_id_ex = block ? 1'b0 : ready_ex_mem;
    assign advance   = ready_id_ex;               // same edge that hands the item on
    // IDLE check lives inside the multiplier, start ignored elsewhere
    assign mul_start = mul_held && ready_ex_mem;
    assign accept    = ready_ex_mem;              // leaves DONE as the register advances

    ex_stage_reg ex_stage_reg_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_ex        (id_ex),
        .valid_id_ex  (valid_id_ex),
        .advance      (advance),
        .branch_flush (branch_flush),
        .held         (held),
        .held_valid   (held_valid)
    );

    ex_forward ex_forward_inst (
        .inst    (held.inst),
        .src_a   (held.src_a),
        .src_b   (held.src_b),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b)
    );

    ex_alu ex_alu_inst (
        .op         (held.op),
        .use_imm    (held.use_imm),
        .pc         (held.pc),
        .imm        (held.imm),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .product    (product),
        .alu_result (alu_result)
    );

    ex_branch ex_branch_inst (
        .op           (held.op),
        .held_valid   (held_valid),
        .ready_ex_mem (ready_ex_mem),
        .pc           (held.pc),
        .imm          (held.imm),
        .inst_sign    (held.inst[INST_W-1]),   // B-imm sign bit
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .target       (alu_result),            // pc+imm for branches
        .dnpc         (dnpc),
        .pc_update    (pc_update)
    );

    ex_multiplier ex_multiplier_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mul_start),
        .abort        (branch_flush),   // flushed MUL must not finish
        .multiplicand (fwd_a),
        .multiplier   (fwd_b),
        .accept       (accept),
        .done         (mul_done),
        .product      (product)
    );

    // toward MEM
    assign valid_ex_mem  = block ? 1'b0 : held_valid;
    assign ex_mem.pc     = held.pc;
    assign ex_mem.inst   = held.inst;
    assign ex_mem.result = alu_result;

endmodule

//--- ex_unit_assert.sv
`timescale 1ns/1ps

module ex_unit_assert (
    input logic            clk,
    input logic            rst_n,
    input logic            valid_ex_mem,
    input logic            ready_ex_mem,
    input logic            ready_id_ex,
    input logic            pc_update,
    input logic            branch_flush,
    input ex_pkg::ex_mem_t ex_mem,
    input ex_pkg::id_ex_t  held,
    input logic            held_valid
);
    import ex_pkg::*;

    // nothing leaves EX in the first cycle out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> (!valid_ex_mem && !pc_update))
        else $error("output valid or redirect in the first cycle after reset");

    a_redirect_valid: assert property (@(posedge clk) disable iff (!rst_n)
        pc_update |-> valid_ex_mem)
        else $error("redirect without a valid output item");

    // a working multiplier closes the decode side
    a_mul_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        (held_valid && (held.op == MUL) && !valid_ex_mem) |-> !ready_id_ex)
        else $error("decode accepted while the multiplier owes a result");

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_ex_mem && !ready_ex_mem && !branch_flush) |=> (valid_ex_mem && $stable(ex_mem)))
        else $error("output changed under back-pressure");

endmodule

bind ex_unit ex_unit_assert ex_unit_assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_ex_mem (valid_ex_mem),
    .ready_ex_mem (ready_ex_mem),
    .ready_id_ex  (ready_id_ex),
    .pc_update    (pc_update),
    .branch_flush (branch_flush),
    .ex_mem       (ex_mem),
    .held         (held),
    .held_valid   (held_valid)
);

//--- files.f
ex_pkg.sv
ex_stage_reg.sv
ex_forward.sv
ex_alu.sv
ex_branch.sv
ex_multiplier.sv
ex_unit.sv
ex_unit_assert.sv
tb_ex_unit.sv

//--- run.sh
#!/bin/sh
# build the EX stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_unit -f files.f \
    && ./obj_dir/Vtb_ex_unit | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb_ex_unit.sv
`timescale 1ns/1ps

module tb_ex_unit;
    import ex_pkg::*;

    localparam logic [63:0] SEED           = 64'd24891;
    localparam int          NUM_ITEMS      = 400;   // offers including bubbles
    localparam int          TIMEOUT_CYCLES = NUM_ITEMS * (MUL_STEPS + 4) + 1000;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            redirect;
        logic [XLEN-1:0] dnpc;
    } outcome_t;

    logic            clk          = 1'b0;
    logic            rst_n        = 1'b0;
    id_ex_t          id_ex        = '0;
    logic            valid_id_ex  = 1'b0;
    logic            ready_ex_mem = 1'b0;
    fwd_src_t        mem_fwd      = '0;
    fwd_src_t        wb_fwd       = '0;
    logic            branch_flush = 1'b0;
    logic            ready_id_ex;
    ex_mem_t         ex_mem;
    logic            valid_ex_mem;
    logic [XLEN-1:0] dnpc;
    logic            pc_update;

    logic [63:0] rng         = SEED;
    id_ex_t      pending[$];           // taken into EX and not out yet
    logic        offer_done  = 1'b0;   // offer used up at the coming edge
    logic        ex_loaded   = 1'b0;   // EX register changes at the coming edge
    int          cycle_count = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          items_out   = 0;
    int          flushed     = 0;

    ex_unit ex_unit_inst (.*);

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        return x ^ (x << 17);
    endfunction

    // MEM beats WB beats the decode value and x0 is never bypassed
    function automatic logic [XLEN-1:0] bypass_operand(input logic [4:0] rs,
            input logic [XLEN-1:0] dec_val, input fwd_src_t m, input fwd_src_t w);
        if (rs == 5'd0) return dec_val;
        if (m.writes && (m.rd == rs)) return m.data;
        if (w.writes && (w.rd == rs)) return w.data;
        return dec_val;
    endfunction

    function automatic outcome_t expected_outcome(input id_ex_t it, input fwd_src_t m,
            input fwd_src_t w);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] c;      // rs2 after bypass
        logic [XLEN-1:0] b;      // operand b after the imm mux
        logic            taken;
        outcome_t        o;
        a = bypass_operand(it.inst[19:15], it.src_a, m, w);
        c = bypass_operand(it.inst[24:20], it.src_b, m, w);
        b = it.use_imm ? it.imm : c;
        case (it.op)
            BEQ:     taken = (a == c);
            BNE:     taken = (a != c);
            BLT:     taken = ($signed(a) < $signed(c));
            BGE:     taken = ($signed(a) >= $signed(c));
            BLTU:    taken = (a < c);
            BGEU:    taken = (a >= c);
            default: taken = 1'b0;
        endcase
        o.redirect = 1'b0;
        o.dnpc     = it.pc + 64'd4;
        case (it.op)
            ADD:  o.result = a + b;
            SUB:  o.result = a - b;
            SLL:  o.result = a << b[5:0];
            SLT:  o.result = {63'd0, $signed(a) < $signed(b)};
            SLTU: o.result = {63'd0, a < b};
            XOR:  o.result = a ^ b;
            SRL:  o.result = a >> b[5:0];
            SRA:  o.result = $unsigned($signed(a) >>> b[5:0]);
            OR:   o.result = a | b;
            AND:  o.result = a & b;
            MUL:  o.result = a * c;   // low 64 bits only
            JALR: begin
                o.result   = it.pc + 64'd4;
                o.redirect = 1'b1;
                o.dnpc     = (a + it.imm) & ~64'd1;
            end
            default: begin   // branches predicted taken when backward
                o.result   = it.pc + it.imm;
                o.redirect = (taken != it.imm[63]);
                if (taken) o.dnpc = it.pc + it.imm;
            end
        endcase
        return o;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
            input logic [XLEN-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic new_offer;
        logic [63:0] r;
        logic [63:0] s;
        logic [63:0] t;
        logic [4:0]  pick;
        rng  = xorshift64(rng);
        r    = rng;
        rng  = xorshift64(rng);
        s    = rng;
        rng  = xorshift64(rng);
        t    = rng;
        pick = r[4:0];
        valid_id_ex   = 1'b1;
        id_ex.use_imm = r[5];
        id_ex.imm     = {{52{r[21]}}, r[21:10]};
        // rs fields limited to x0..x3 so bypass hits are common
        id_ex.inst    = {r[21], r[43:38], 3'b000, r[9:8], 3'b000, r[7:6], r[37:23]};
        id_ex.pc      = {42'd0, r[63:44], 2'b00};
        id_ex.src_a   = s;
        id_ex.src_b   = r[22] ? s : t;   // equal operands now and then
        if (pick < 5'd16) id_ex.op = ex_op_e'(int'(ADD) + int'(pick % 5'd10));
        else if (pick < 5'd20) id_ex.op = MUL;
        else if (pick < 5'd26) id_ex.op = ex_op_e'(int'(BEQ) + int'(pick - 5'd20));
        else if (pick < 5'd28) id_ex.op = JALR;
        else valid_id_ex = 1'b0;         // bubble
    endtask

    task automatic new_forwarding;
        rng = xorshift64(rng);
        mem_fwd.writes = rng[0];
        mem_fwd.rd     = {3'b000, rng[2:1]};
        wb_fwd.writes  = rng[3];
        wb_fwd.rd      = {3'b000, rng[5:4]};
        rng = xorshift64(rng);
        mem_fwd.data   = rng;
        rng = xorshift64(rng);
        wb_fwd.data    = rng;
    endtask

    // inputs change 1 ns after the edge so at the falling edge
    // everything already holds what the next rising edge will see
    always @(negedge clk) begin : scoreboard
        id_ex_t   item;
        outcome_t want;
        if (rst_n) begin
            if (branch_flush) begin
                if (pending.size() > 0) begin
                    void'(pending.pop_front());   // killed in EX
                    flushed++;
                end
            end else if (valid_ex_mem && ready_ex_mem) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("an item left EX at %0d ns with nothing expected", $time);
                end else begin
                    item = pending.pop_front();
                    want = expected_outcome(item, mem_fwd, wb_fwd);
                    check_value("ex_mem.pc", ex_mem.pc, item.pc);
                    check_value("ex_mem.inst", XLEN'(ex_mem.inst), XLEN'(item.inst));
                    check_value("ex_mem.result", ex_mem.result, want.result);
                    check_value("pc_update", XLEN'(pc_update), XLEN'(want.redirect));
                    if (want.redirect) check_value("dnpc", dnpc, want.dnpc);
                    items_out++;
                end
            end else if (pc_update) begin
                errors++;
                $display("redirect raised at %0d ns while no item left EX", $time);
            end
            if (valid_id_ex && ready_id_ex && !branch_flush) pending.push_back(id_ex);
            offer_done = !valid_id_ex || ready_id_ex || branch_flush;
            ex_loaded  = ready_id_ex || branch_flush;
        end
    end

    initial begin : stimulus
        int consumed;
        consumed = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        new_offer();
        new_forwarding();
        while (consumed < NUM_ITEMS) begin
            @(posedge clk);
            #1;
            if (offer_done) begin
                consumed++;
                if (consumed < NUM_ITEMS) new_offer();
                else valid_id_ex = 1'b0;
            end
            if (ex_loaded) new_forwarding();   // records stay fixed while an item sits in EX
            rng = xorshift64(rng);
            ready_ex_mem = (rng[1:0] != 2'b00);   // ready 3 cycles in 4
            branch_flush = (rng[8:2] == 7'd0);    // about 1 in 128
        end
        ready_ex_mem = 1'b1;   // drain
        branch_flush = 1'b0;
        while (pending.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("checks %0d, items out %0d, flushed %0d, errors %0d",
                 checks, items_out, flushed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the stage stopped delivering items", cycle_count);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
